/* design/fm_pac_pkg.sv */
package fm_pac_pkg;

   // One CPU bus cycle as seen by the cartridge slots.
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        cs;
      logic        rd;
      logic        wr;
      logic        mreq;
   } cpu_bus_t;

   // Request towards ROM or battery SRAM.
   typedef struct packed {
      logic [24:0] addr;
      logic        sram_cs;
      logic        sram_we;
   } mem_req_t;

   // One complete register write for the sound chip.
   typedef struct packed {
      logic [7:0] reg_index;
      logic [7:0] data;
   } opll_write_t;

   // Register offsets inside the 16 KiB cartridge window.
   localparam logic [13:0] reg_enable_ofs = 14'h3FF6;
   localparam logic [13:0] reg_bank_ofs   = 14'h3FF7;
   localparam logic [13:0] magic_lo_ofs   = 14'h1FFE;
   localparam logic [13:0] magic_hi_ofs   = 14'h1FFF;
   localparam logic [13:0] opll_addr_ofs  = 14'h3FF4;
   localparam logic [13:0] opll_data_ofs  = 14'h3FF5;

   // SRAM is writable only while the two magic bytes hold this value.
   localparam logic [15:0] sram_magic = 16'h694D;

endpackage

/* design/fm_pac_mapper.sv */
`timescale 1ns/100ps

module fm_pac_mapper #(
   parameter int sram_addr_bits = 13
) (
   input  logic                 clk,
   input  logic                 reset,
   input  fm_pac_pkg::cpu_bus_t bus,
   output logic [7:0]           reg_rdata,
   output logic                 reg_hit,
   output fm_pac_pkg::mem_req_t mem,
   output logic                 opll_strobe,
   output logic                 opll_port,
   output logic [7:0]           opll_data,
   output logic                 opll_io_enable
);

   logic [7:0]  enable;
   logic [1:0]  bank;
   logic [7:0]  magic_lo;
   logic [7:0]  magic_hi;
   logic        last_rw;
   logic [13:0] ofs;
   logic        wr_cycle;
   logic        rd_cycle;
   logic        unlocked;
   logic        sram_cs;

   assign ofs      = bus.addr[13:0];
   assign wr_cycle = bus.cs & bus.wr & bus.mreq;
   assign rd_cycle = bus.cs & bus.rd & bus.mreq;
   assign unlocked = ({magic_hi, magic_lo} == fm_pac_pkg::sram_magic);

   assign opll_io_enable = enable[0];

   // Writes to either OPLL port are passed on as a strobe with the port bit.
   assign opll_strobe = wr_cycle & ((ofs == fm_pac_pkg::opll_addr_ofs) |
                                    (ofs == fm_pac_pkg::opll_data_ofs));
   assign opll_port   = bus.addr[0];
   assign opll_data   = bus.wdata;

   // The magic bytes only read back once SRAM has been unlocked.
   always_comb begin
      reg_hit   = 1'b0;
      reg_rdata = 8'hFF;
      if (ofs == fm_pac_pkg::reg_enable_ofs) begin
         reg_hit   = rd_cycle;
         reg_rdata = enable;
      end else if (ofs == fm_pac_pkg::reg_bank_ofs) begin
         reg_hit   = rd_cycle;
         reg_rdata = {6'b000000, bank};
      end else if (ofs == fm_pac_pkg::magic_lo_ofs && unlocked) begin
         reg_hit   = rd_cycle;
         reg_rdata = magic_lo;
      end else if (ofs == fm_pac_pkg::magic_hi_ofs && unlocked) begin
         reg_hit   = rd_cycle;
         reg_rdata = magic_hi;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         enable   <= 8'h00;
         bank     <= 2'b00;
         magic_lo <= 8'h00;
         magic_hi <= 8'h00;
         last_rw  <= 1'b0;
      end else begin
         last_rw <= bus.rd | bus.wr;
         if (wr_cycle) begin
            case (ofs)
               fm_pac_pkg::magic_lo_ofs: begin
                  if (!enable[4]) begin
                     magic_lo <= bus.wdata;
                  end
               end
               fm_pac_pkg::magic_hi_ofs: begin
                  if (!enable[4]) begin
                     magic_hi <= bus.wdata;
                  end
               end
               fm_pac_pkg::reg_enable_ofs: begin
                  enable <= bus.wdata & 8'h11;
                  // With the lock bit already set, rewriting enable drops the unlock.
                  if (enable[4]) begin
                     magic_lo <= 8'h00;
                     magic_hi <= 8'h00;
                  end
               end
               fm_pac_pkg::reg_bank_ofs: begin
                  bank <= bus.wdata[1:0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // A write selects SRAM only in its first cycle, so a held write is stored once.
   assign sram_cs = bus.cs & unlocked & ~bus.addr[13] &
                    ((~last_rw & bus.wr) | bus.rd);

   always_comb begin
      mem.sram_cs = sram_cs;
      mem.sram_we = sram_cs & bus.wr & bus.mreq;
      if (sram_cs) begin
         mem.addr = 25'(bus.addr[sram_addr_bits-1:0]);
      end else begin
         mem.addr = 25'({bank, ofs});
      end
   end

endmodule

/* design/opll_port_latch.sv */
`timescale 1ns/100ps

module opll_port_latch (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    strobe,
   input  logic                    port,
   input  logic [7:0]              data,
   output fm_pac_pkg::opll_write_t wr_out,
   output logic                    wr_valid
);

   logic [7:0]              reg_index;
   fm_pac_pkg::opll_write_t record;

   // Port 0 selects the register, the index waits for the data write.
   always_ff @(posedge clk) begin
      if (strobe && !port) begin
         reg_index <= data;
      end
   end

   // Port 1 completes the pair and sends it out as one record.
   always_ff @(posedge clk) begin
      if (strobe && port) begin
         record.reg_index <= reg_index;
         record.data      <= data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_valid <= 1'b0;
      end else begin
         wr_valid <= strobe & port;
      end
   end

   assign wr_out = record;

endmodule

/* design/cart_sram.sv */
`timescale 1ns/100ps

module cart_sram #(
   parameter int sram_addr_bits = 13
) (
   input  logic                 clk,
   input  fm_pac_pkg::mem_req_t mem,
   input  logic [7:0]           wdata,
   output logic [7:0]           rdata,
   output logic                 rvalid
);

   localparam int depth = 2 ** sram_addr_bits;

   logic [7:0]                mem_array [depth];
   logic [sram_addr_bits-1:0] addr;
   logic                      rd_req;

   assign addr   = mem.addr[sram_addr_bits-1:0];
   assign rd_req = mem.sram_cs & ~mem.sram_we;

   always_ff @(posedge clk) begin
      if (mem.sram_cs && mem.sram_we) begin
         mem_array[addr] <= wdata;
      end
   end

   // Read data is registered and valid in the cycle after the request.
   always_ff @(posedge clk) begin
      if (rd_req) begin
         rdata <= mem_array[addr];
      end
      rvalid <= rd_req;
   end

endmodule

/* design/fm_pac_slots.sv */
`timescale 1ns/100ps

module fm_pac_slots #(
   parameter int sram_addr_bits = 13
) (
   input  logic                    clk,
   input  logic                    reset,
   input  fm_pac_pkg::cpu_bus_t    bus,
   input  logic                    slot,
   output logic [7:0]              rdata,
   output logic                    rdata_valid,
   output fm_pac_pkg::mem_req_t    mem,
   output logic                    mem_unmapped,
   output logic [1:0]              opll_io_enable,
   output fm_pac_pkg::opll_write_t opll_a,
   output logic                    opll_a_valid,
   output fm_pac_pkg::opll_write_t opll_b,
   output logic                    opll_b_valid
);

   fm_pac_pkg::cpu_bus_t bus_a;
   fm_pac_pkg::cpu_bus_t bus_b;
   fm_pac_pkg::mem_req_t mem_a;
   fm_pac_pkg::mem_req_t mem_b;
   logic [7:0]           reg_rdata_a;
   logic [7:0]           reg_rdata_b;
   logic                 reg_hit_a;
   logic                 reg_hit_b;
   logic [7:0]           sram_rdata_a;
   logic [7:0]           sram_rdata_b;
   logic                 sram_rvalid_a;
   logic                 sram_rvalid_b;
   logic                 strobe_a;
   logic                 strobe_b;
   logic                 port_a;
   logic                 port_b;
   logic [7:0]           opll_data_a;
   logic [7:0]           opll_data_b;
   logic                 reg_hit;
   logic [7:0]           reg_rdata;

   // Only the selected slot sees its chip select.
   always_comb begin
      bus_a    = bus;
      bus_b    = bus;
      bus_a.cs = bus.cs & ~slot;
      bus_b.cs = bus.cs & slot;
   end

   fm_pac_mapper #(.sram_addr_bits(sram_addr_bits)) mapper_a (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus_a),
      .reg_rdata      (reg_rdata_a),
      .reg_hit        (reg_hit_a),
      .mem            (mem_a),
      .opll_strobe    (strobe_a),
      .opll_port      (port_a),
      .opll_data      (opll_data_a),
      .opll_io_enable (opll_io_enable[0])
   );

   fm_pac_mapper #(.sram_addr_bits(sram_addr_bits)) mapper_b (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus_b),
      .reg_rdata      (reg_rdata_b),
      .reg_hit        (reg_hit_b),
      .mem            (mem_b),
      .opll_strobe    (strobe_b),
      .opll_port      (port_b),
      .opll_data      (opll_data_b),
      .opll_io_enable (opll_io_enable[1])
   );

   cart_sram #(.sram_addr_bits(sram_addr_bits)) sram_a (
      .clk    (clk),
      .mem    (mem_a),
      .wdata  (bus.wdata),
      .rdata  (sram_rdata_a),
      .rvalid (sram_rvalid_a)
   );

   cart_sram #(.sram_addr_bits(sram_addr_bits)) sram_b (
      .clk    (clk),
      .mem    (mem_b),
      .wdata  (bus.wdata),
      .rdata  (sram_rdata_b),
      .rvalid (sram_rvalid_b)
   );

   opll_port_latch latch_a (
      .clk      (clk),
      .reset    (reset),
      .strobe   (strobe_a),
      .port     (port_a),
      .data     (opll_data_a),
      .wr_out   (opll_a),
      .wr_valid (opll_a_valid)
   );

   opll_port_latch latch_b (
      .clk      (clk),
      .reset    (reset),
      .strobe   (strobe_b),
      .port     (port_b),
      .data     (opll_data_b),
      .wr_out   (opll_b),
      .wr_valid (opll_b_valid)
   );

   assign mem       = slot ? mem_b : mem_a;
   assign reg_hit   = slot ? reg_hit_b : reg_hit_a;
   assign reg_rdata = slot ? reg_rdata_b : reg_rdata_a;

   // A register hit answers at once. SRAM data arrives a cycle later
   // from whichever slot issued the read, so its valid picks the byte.
   always_comb begin
      if (reg_hit) begin
         rdata = reg_rdata;
      end else if (sram_rvalid_b) begin
         rdata = sram_rdata_b;
      end else begin
         rdata = sram_rdata_a;
      end
   end

   assign rdata_valid = reg_hit | sram_rvalid_a | sram_rvalid_b;

   // The cartridges only decode page 1, 4000 to 7FFF.
   assign mem_unmapped = bus.cs & ((bus.addr < 16'h4000) | (bus.addr >= 16'h8000));

endmodule

/* bench/fm_pac_assert.sv */
`timescale 1ns/100ps

module fm_pac_assert #(
   parameter int sram_addr_bits = 13
) (
   input logic                    clk,
   input logic                    reset,
   input fm_pac_pkg::cpu_bus_t    bus,
   input logic                    slot,
   input logic [7:0]              rdata,
   input logic                    rdata_valid,
   input fm_pac_pkg::mem_req_t    mem,
   input logic                    mem_unmapped,
   input logic [1:0]              opll_io_enable,
   input fm_pac_pkg::opll_write_t opll_a,
   input logic                    opll_a_valid,
   input fm_pac_pkg::opll_write_t opll_b,
   input logic                    opll_b_valid
);

   localparam int depth = 2 ** sram_addr_bits;

   int unsigned fail_count = 0;

   // Shadow state per slot is rebuilt from the CPU bus alone.
   logic [1:0]                bank [2];
   logic [15:0]               magic [2];
   logic [7:0]                opll_index [2];
   logic [1:0]                lock;
   logic [1:0]                io_en;
   logic                      seen_write;
   logic                      prev_rw;
   logic [7:0]                shadow_mem [2][depth];
   logic [1:0][depth-1:0]     written;
   logic                      rd_pend;
   logic [7:0]                rd_exp;
   logic [1:0]                opll_pend;
   fm_pac_pkg::opll_write_t   opll_exp [2];
   fm_pac_pkg::opll_write_t   opll_rec [2];
   logic [1:0]                opll_valid;
   logic [13:0]               ofs;
   logic [sram_addr_bits-1:0] sram_addr;
   logic                      wr_cyc;
   logic                      rd_cyc;
   logic                      unlocked;
   logic                      sram_area;
   logic                      exp_sram_cs;
   logic [7:0]                exp_bank_rd;
   logic [24:0]               exp_rom_addr;
   logic                      exp_unmapped;

   assign ofs          = bus.addr[13:0];
   assign sram_addr    = bus.addr[sram_addr_bits-1:0];
   assign wr_cyc       = bus.cs & bus.wr & bus.mreq;
   assign rd_cyc       = bus.cs & bus.rd & bus.mreq;
   assign unlocked     = (magic[slot] == fm_pac_pkg::sram_magic);
   assign sram_area    = bus.cs & unlocked & ~bus.addr[13];
   assign exp_bank_rd  = {6'b000000, bank[slot]};
   assign exp_rom_addr = 25'({bank[slot], ofs});
   assign exp_unmapped = bus.cs & (bus.addr[15:14] != 2'b01);
   assign opll_rec[0]  = opll_a;
   assign opll_rec[1]  = opll_b;
   assign opll_valid   = {opll_b_valid, opll_a_valid};

   // A write held on the bus selects SRAM only in its first cycle.
   assign exp_sram_cs  = sram_area & (bus.rd | (bus.wr & ~prev_rw));

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < 2; s++) begin
            bank[s]  <= 2'b00;
            magic[s] <= 16'h0000;
         end
         lock       <= 2'b00;
         io_en      <= 2'b00;
         seen_write <= 1'b0;
         prev_rw    <= 1'b0;
         written    <= '0;
         rd_pend    <= 1'b0;
         opll_pend  <= 2'b00;
      end else begin
         prev_rw   <= bus.rd | bus.wr;
         rd_pend   <= rd_cyc & sram_area & written[slot][sram_addr];
         rd_exp    <= shadow_mem[slot][sram_addr];
         opll_pend <= 2'b00;
         if (wr_cyc) begin
            seen_write <= 1'b1;
            if (sram_area) begin
               shadow_mem[slot][sram_addr] <= bus.wdata;
               written[slot][sram_addr]    <= 1'b1;
            end
            case (ofs)
               fm_pac_pkg::magic_lo_ofs: begin
                  if (!lock[slot]) begin
                     magic[slot][7:0] <= bus.wdata;
                  end
               end
               fm_pac_pkg::magic_hi_ofs: begin
                  if (!lock[slot]) begin
                     magic[slot][15:8] <= bus.wdata;
                  end
               end
               fm_pac_pkg::reg_enable_ofs: begin
                  lock[slot]  <= bus.wdata[4];
                  io_en[slot] <= bus.wdata[0];
                  if (lock[slot]) begin
                     magic[slot] <= 16'h0000;
                  end
               end
               fm_pac_pkg::reg_bank_ofs: begin
                  bank[slot] <= bus.wdata[1:0];
               end
               fm_pac_pkg::opll_addr_ofs: begin
                  opll_index[slot] <= bus.wdata;
               end
               fm_pac_pkg::opll_data_ofs: begin
                  opll_pend[slot] <= 1'b1;
                  opll_exp[slot]  <= {opll_index[slot], bus.wdata};
               end
               default: begin
               end
            endcase
         end
      end
   end

   quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
      !seen_write |-> !(opll_a_valid | opll_b_valid | (|opll_io_enable) |
                        mem.sram_cs | mem.sram_we))
      else begin
         $error("mismatch after reset: opll valids %h opll_io_enable %h sram_cs %h sram_we %h",
                $sampled({opll_b_valid, opll_a_valid}), $sampled(opll_io_enable),
                $sampled(mem.sram_cs), $sampled(mem.sram_we));
         fail_count++;
      end

   io_enable_tracks: assert property (@(posedge clk) disable iff (reset)
      opll_io_enable == io_en)
      else begin
         $error("mismatch opll_io_enable: got %h expected %h",
                $sampled(opll_io_enable), $sampled(io_en));
         fail_count++;
      end

   bank_readback: assert property (@(posedge clk) disable iff (reset)
      rd_cyc && ofs == fm_pac_pkg::reg_bank_ofs |-> rdata_valid && rdata == exp_bank_rd)
      else begin
         $error("mismatch rdata: got %h expected %h, valid %h",
                $sampled(rdata), $sampled(exp_bank_rd), $sampled(rdata_valid));
         fail_count++;
      end

   rom_mapping: assert property (@(posedge clk) disable iff (reset)
      bus.cs && !mem.sram_cs |-> mem.addr == exp_rom_addr)
      else begin
         $error("mismatch mem.addr: got %h expected %h",
                $sampled(mem.addr), $sampled(exp_rom_addr));
         fail_count++;
      end

   sram_select: assert property (@(posedge clk) disable iff (reset)
      mem.sram_cs == exp_sram_cs)
      else begin
         $error("mismatch mem.sram_cs: got %h expected %h",
                $sampled(mem.sram_cs), $sampled(exp_sram_cs));
         fail_count++;
      end

   // Registered read data belongs to the request seen one edge earlier.
   sram_readback: assert property (@(posedge clk) disable iff (reset)
      rd_pend |-> rdata_valid && rdata == rd_exp)
      else begin
         $error("mismatch rdata: got %h expected %h, valid %h",
                $sampled(rdata), $sampled(rd_exp), $sampled(rdata_valid));
         fail_count++;
      end

   for (genvar s = 0; s < 2; s++) begin : g_opll
      opll_pulse: assert property (@(posedge clk) disable iff (reset)
         opll_valid[s] == opll_pend[s])
         else begin
            $error("mismatch opll valid of slot %0d: got %h expected %h",
                   s, $sampled(opll_valid[s]), $sampled(opll_pend[s]));
            fail_count++;
         end

      opll_record: assert property (@(posedge clk) disable iff (reset)
         opll_pend[s] |-> opll_rec[s] == opll_exp[s])
         else begin
            $error("mismatch opll record of slot %0d: got %h expected %h",
                   s, $sampled(opll_rec[s]), $sampled(opll_exp[s]));
            fail_count++;
         end
   end

   unmapped_decode: assert property (@(posedge clk) disable iff (reset)
      mem_unmapped == exp_unmapped)
      else begin
         $error("mismatch mem_unmapped: got %h expected %h",
                $sampled(mem_unmapped), $sampled(exp_unmapped));
         fail_count++;
      end

endmodule

bind fm_pac_slots fm_pac_assert #(.sram_addr_bits(sram_addr_bits)) checks (
   .clk            (clk),
   .reset          (reset),
   .bus            (bus),
   .slot           (slot),
   .rdata          (rdata),
   .rdata_valid    (rdata_valid),
   .mem            (mem),
   .mem_unmapped   (mem_unmapped),
   .opll_io_enable (opll_io_enable),
   .opll_a         (opll_a),
   .opll_a_valid   (opll_a_valid),
   .opll_b         (opll_b),
   .opll_b_valid   (opll_b_valid)
);

/* bench/fm_pac_tb.sv */
`timescale 1ns/100ps

module fm_pac_tb;

   localparam int clk_half    = 10;
   localparam int test_count  = 6;
   localparam int test_cycles = 200;

   logic                    clk;
   logic                    reset;
   fm_pac_pkg::cpu_bus_t    bus;
   logic                    slot;
   logic [7:0]              rdata;
   logic                    rdata_valid;
   fm_pac_pkg::mem_req_t    mem;
   logic                    mem_unmapped;
   logic [1:0]              opll_io_enable;
   fm_pac_pkg::opll_write_t opll_a;
   logic                    opll_a_valid;
   fm_pac_pkg::opll_write_t opll_b;
   logic                    opll_b_valid;
   int unsigned             tests_run;
   int unsigned             fails_before;
   logic [15:0]             page_edges [4] = '{16'h3FFF, 16'h4000, 16'h7FFF, 16'h8000};

   fm_pac_slots #(.sram_addr_bits(13)) DUT (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus),
      .slot           (slot),
      .rdata          (rdata),
      .rdata_valid    (rdata_valid),
      .mem            (mem),
      .mem_unmapped   (mem_unmapped),
      .opll_io_enable (opll_io_enable),
      .opll_a         (opll_a),
      .opll_a_valid   (opll_a_valid),
      .opll_b         (opll_b),
      .opll_b_valid   (opll_b_valid)
   );

   always #clk_half clk = ~clk;

   // One bus cycle held for one clock, then the bus goes idle for at least one clock.
   task automatic cpu_cycle(input logic s, input logic [15:0] addr, input logic [7:0] data,
                            input logic write, input logic sel);
      @(posedge clk);
      #2;
      slot      = s;
      bus.addr  = addr;
      bus.wdata = data;
      bus.cs    = sel;
      bus.rd    = ~write;
      bus.wr    = write;
      bus.mreq  = 1'b1;
      @(posedge clk);
      #2;
      bus = '0;
   endtask

   task automatic bus_write(input logic s, input logic [13:0] ofs, input logic [7:0] data);
      cpu_cycle(s, {2'b01, ofs}, data, 1'b1, 1'b1);
   endtask

   task automatic bus_read(input logic s, input logic [13:0] ofs);
      cpu_cycle(s, {2'b01, ofs}, 8'h00, 1'b0, 1'b1);
   endtask

   task automatic report_test(input string name);
      int unsigned now_fails;
      repeat (2) @(posedge clk);
      #1;
      now_fails = DUT.checks.fail_count;
      tests_run++;
      $display("test %0d %s: %0d assertion failures", tests_run, name, now_fails - fails_before);
      fails_before = now_fails;
   endtask

   initial begin
      #(2 * clk_half * (test_count * test_cycles + 100));
      $display("timeout: the tests did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      logic [13:0] ofs;
      logic [7:0]  data;
      logic        s;
      int unsigned fails;
      void'($urandom(32'h6be48cda));
      clk          = 1'b0;
      reset        = 1'b1;
      slot         = 1'b0;
      bus          = '0;
      tests_run    = 0;
      fails_before = 0;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;

      // Reads alone must leave every strobe and select low.
      for (int i = 0; i < 20; i++) begin
         bus_read(1'($urandom), 14'($urandom));
      end
      report_test("reset state");

      for (int k = 0; k < 2; k++) begin
         for (int b = 0; b < 4; b++) begin
            bus_write(1'(k), fm_pac_pkg::reg_bank_ofs, {6'($urandom), 2'(b)});
            bus_read(1'(k), fm_pac_pkg::reg_bank_ofs);
            bus_read(1'(k), 14'($urandom_range(14'h3FEF)));
         end
      end
      report_test("bank mapping");

      for (int k = 0; k < 2; k++) begin
         bus_write(1'(k), fm_pac_pkg::magic_lo_ofs, 8'h4D);
         bus_write(1'(k), fm_pac_pkg::magic_hi_ofs, 8'h69);
      end
      for (int i = 0; i < 8; i++) begin
         ofs = 14'($urandom_range(14'h1FFD));
         bus_write(1'b0, ofs, 8'($urandom));
         bus_write(1'b1, ofs, 8'($urandom));
         bus_read(1'b0, ofs);
         bus_read(1'b1, ofs);
      end
      report_test("sram unlock");

      ofs  = 14'($urandom_range(14'h1FFD));
      data = 8'($urandom);
      bus_write(1'b0, ofs, data);
      bus_write(1'b0, fm_pac_pkg::reg_enable_ofs, 8'h10);
      bus_write(1'b0, fm_pac_pkg::magic_lo_ofs, 8'h00);
      bus_write(1'b0, fm_pac_pkg::magic_hi_ofs, 8'h00);
      bus_read(1'b0, ofs);
      bus_write(1'b0, fm_pac_pkg::reg_enable_ofs, 8'h10);
      bus_write(1'b0, ofs, ~data);
      bus_read(1'b0, ofs);
      bus_write(1'b0, fm_pac_pkg::reg_enable_ofs, 8'h00);
      bus_write(1'b0, fm_pac_pkg::magic_lo_ofs, 8'h4D);
      bus_write(1'b0, fm_pac_pkg::magic_hi_ofs, 8'h69);
      bus_read(1'b0, ofs);
      report_test("sram lock");

      bus_write(1'b0, fm_pac_pkg::reg_enable_ofs, 8'h01);
      bus_write(1'b1, fm_pac_pkg::reg_enable_ofs, 8'h01);
      for (int i = 0; i < 10; i++) begin
         s = 1'($urandom);
         bus_write(s, fm_pac_pkg::opll_addr_ofs, 8'($urandom));
         bus_write(s, fm_pac_pkg::opll_data_ofs, 8'($urandom));
      end
      report_test("opll writes");

      foreach (page_edges[i]) begin
         cpu_cycle(1'($urandom), page_edges[i], 8'h00, 1'b0, 1'b1);
      end
      for (int i = 0; i < 60; i++) begin
         cpu_cycle(1'($urandom), 16'($urandom), 8'h00, 1'b0, 1'($urandom));
      end
      report_test("unmapped decode");

      fails = DUT.checks.fail_count;
      $display("%0d tests run, %0d assertion failures", tests_run, fails);
      if (fails == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* fm_pac_cart.f */
design/fm_pac_pkg.sv
design/fm_pac_mapper.sv
design/opll_port_latch.sv
design/cart_sram.sv
design/fm_pac_slots.sv
bench/fm_pac_assert.sv
bench/fm_pac_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fm_pac_tb
FILELIST  ?= fm_pac_cart.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# The simulator is rebuilt only when a source or the file list changes.
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
